// File: Makefile
TOP := tb_fetch_cache

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f fetch_cache_top.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Some tests failed" sim.log || ! grep -q "All tests passed" sim.log; then \
		echo "Simulation FAILED"; \
		exit 1; \
	else \
		echo "Simulation OK"; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: fetch_cache_top.f
+incdir+rtl
rtl/icache_pkg.sv
rtl/line_sram.sv
rtl/icache.sv
rtl/backing_mem.sv
rtl/fetch_cache_top.sv
test/tb_fetch_cache.sv

// File: rtl/backing_mem.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module backing_mem (
	input  logic              clk,
	input  logic              load_en,
	input  icache_pkg::addr_t load_addr,
	input  icache_pkg::inst_t load_data,
	input  icache_pkg::addr_t refill_addr,
	output icache_pkg::line_t refill_line
);
	import icache_pkg::*;

	localparam int WORD_IDX_W = $clog2(`ICACHE_MEM_WORDS);
	localparam int LINE_WORDS = `ICACHE_LINE_W / $bits(inst_t);

	inst_t mem [`ICACHE_MEM_WORDS];

	logic [WORD_IDX_W-1:0] load_idx;
	logic [WORD_IDX_W-1:0] line_base;

	// Byte addresses wrap at the memory depth
	assign load_idx  = load_addr[WORD_IDX_W+1:2];
	assign line_base = {refill_addr[WORD_IDX_W+1:OFFSET_W], {(OFFSET_W-2){1'b0}}};

	// Unloaded words read back as zero
	initial begin
		for (int i = 0; i < `ICACHE_MEM_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	always @(posedge clk) begin
		if (load_en) mem[load_idx] <= load_data;
	end

	// Lowest address lands in the low bits of the line
	always_comb begin
		for (int k = 0; k < LINE_WORDS; k++) begin
			refill_line[k*32 +: 32] = mem[line_base + WORD_IDX_W'(k)];
		end
	end

endmodule

// File: rtl/fetch_cache_top.sv
`timescale 1ns/1ps

module fetch_cache_top (
	input  logic              clk,
	input  logic              rst,

	// Fetch stage
	input  icache_pkg::addr_t addr,
	input  logic              valid,
	input  logic              flush,
	input  logic              id_ready,
	output icache_pkg::inst_t inst,
	output logic              inst_ready,

	// Program loader
	input  logic              load_en,
	input  icache_pkg::addr_t load_addr,
	input  icache_pkg::inst_t load_data
);
	import icache_pkg::*;

	addr_t refill_addr;
	line_t refill_line;                     // Combinational, same cycle as the request

	icache u_icache (
		.clk         (clk),
		.rst         (rst),
		.addr        (addr),
		.valid       (valid),
		.flush       (flush),
		.id_ready    (id_ready),
		.inst        (inst),
		.inst_ready  (inst_ready),
		.refill_addr (refill_addr),
		.refill_line (refill_line)
	);

	backing_mem u_mem (
		.clk         (clk),
		.load_en     (load_en),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.refill_addr (refill_addr),
		.refill_line (refill_line)
	);

endmodule

// File: rtl/icache.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache (
	input  logic                clk,
	input  logic                rst,
	input  icache_pkg::addr_t   addr,
	input  logic                valid,
	input  logic                flush,
	input  logic                id_ready,
	output icache_pkg::inst_t   inst,
	output logic                inst_ready,
	output icache_pkg::addr_t   refill_addr,
	input  icache_pkg::line_t   refill_line
);
	import icache_pkg::*;

	localparam int WAYS = $bits(way_mask_t);

	set_idx_t  index;
	tag_t      tag;
	way_mask_t hit;
	logic      accept;
	logic      miss;

	way_mask_t victim;                      // Rotating one-hot replacement pointer

	tag_t                    tag_q   [WAYS][`ICACHE_SETS];
	logic [`ICACHE_SETS-1:0] valid_q [WAYS];

	way_mask_t sram_cen;
	way_mask_t sram_wen;
	set_idx_t  sram_addr;
	line_t     sram_wdata;
	line_t     sram_rdata [WAYS];

	// Fetch in flight, captured at acceptance
	addr_t     addr_q;
	way_mask_t hit_q;
	line_t     line_q;

	line_t                line_out;
	logic [OFFSET_W-3:0]  word_sel;

	assign index = addr[OFFSET_W +: INDEX_W];
	assign tag   = addr[`ICACHE_ADDR_W-1 -: TAG_W];

	assign accept = valid && id_ready;
	assign miss   = (hit == '0);

	// Line base of the request, memory answers in the same cycle
	assign refill_addr = {addr[`ICACHE_ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

	// Parallel tag compare across all ways
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			hit[w] = valid_q[w][index] && (tag_q[w][index] == tag);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < WAYS; w++) begin
				valid_q[w] <= '0;
			end
		end else if (accept && miss) begin
			for (int w = 0; w < WAYS; w++) begin
				if (victim[w]) valid_q[w][index] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept && miss) begin
			for (int w = 0; w < WAYS; w++) begin
				if (victim[w]) tag_q[w][index] <= tag;
			end
		end
	end

	// Pointer advances on every unflushed cycle, request or not
	always_ff @(posedge clk) begin
		if (rst) begin
			victim <= way_mask_t'(1);
		end else if (id_ready && !flush) begin
			victim <= {victim[WAYS-2:0], victim[WAYS-1]};
		end
	end

	// Hit reads its own way, miss writes the victim way
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			sram_cen[w] = accept && (hit[w] || (miss && victim[w]));
			sram_wen[w] = accept && miss && victim[w];
		end
	end

	assign sram_addr  = index;
	assign sram_wdata = refill_line;

	for (genvar w = 0; w < WAYS; w++) begin : g_way
		line_sram u_sram (
			.clk   (clk),
			.cen   (sram_cen[w]),
			.wen   (sram_wen[w]),
			.addr  (sram_addr),
			.wdata (sram_wdata),
			.rdata (sram_rdata[w])
		);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			inst_ready <= 1'b0;
		end else if (id_ready) begin
			inst_ready <= valid && !flush;  // Flush kills the fetch in flight
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q <= addr;
			hit_q  <= hit;
			line_q <= refill_line;
		end
	end

	// SRAM output on a hit, otherwise the line fetched on the miss
	always_comb begin
		line_out = line_q;
		for (int w = 0; w < WAYS; w++) begin
			if (hit_q[w]) line_out = sram_rdata[w];
		end
	end

	assign word_sel = addr_q[OFFSET_W-1:2];
	assign inst     = line_out[word_sel*32 +: 32];

	// A line is only filled on a miss, so two ways never share a tag
	assert property (@(posedge clk) disable iff (rst) valid |-> $onehot0(hit))
		else $error("icache: more than one way hit");

	assert property (@(posedge clk) disable iff (rst) $onehot(victim))
		else $error("icache: replacement pointer not one-hot");

	assert property (@(posedge clk) rst |=> !inst_ready)
		else $error("icache: inst_ready high after reset");

endmodule

// File: rtl/icache_pkg.sv
`include "icache_settings.svh"

package icache_pkg;

	// Address split: tag | index | byte offset within the line
	localparam int OFFSET_W = $clog2(`ICACHE_LINE_W / 8);
	localparam int INDEX_W  = $clog2(`ICACHE_SETS);
	localparam int TAG_W    = `ICACHE_ADDR_W - INDEX_W - OFFSET_W;

	typedef logic [`ICACHE_ADDR_W-1:0] addr_t;
	typedef logic [`ICACHE_LINE_W-1:0] line_t;
	typedef logic [31:0]               inst_t;
	typedef logic [INDEX_W-1:0]        set_idx_t;
	typedef logic [TAG_W-1:0]          tag_t;

	// One bit per way, used for hits and for the victim pointer
	typedef logic [3:0]                way_mask_t;

endpackage

// File: rtl/icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// Fetch address width in bits
`define ICACHE_ADDR_W 64

// One cache line, four instruction words
`define ICACHE_LINE_W 128

// Sets per way, indexed by address bits 9 to 4
`define ICACHE_SETS 64

// Backing memory depth in 32-bit words
`define ICACHE_MEM_WORDS 4096

`endif

// File: rtl/line_sram.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module line_sram (
	input  logic                 clk,
	input  logic                 cen,
	input  logic                 wen,
	input  icache_pkg::set_idx_t addr,
	input  icache_pkg::line_t    wdata,
	output icache_pkg::line_t    rdata
);
	import icache_pkg::*;

	line_t mem [`ICACHE_SETS];

	// Write leaves rdata alone, read registers the stored line
	always_ff @(posedge clk) begin
		if (cen) begin
			if (wen) begin
				mem[addr] <= wdata;
			end else begin
				rdata <= mem[addr];
			end
		end
	end

	// An enabled access must point at a real row
	assert property (@(posedge clk) cen |-> !$isunknown(addr))
		else $error("line_sram: unknown address on enabled access");

	// Read or write must be decided whenever the macro is selected
	assert property (@(posedge clk) cen |-> !$isunknown(wen))
		else $error("line_sram: unknown write enable on enabled access");

endmodule

// File: test/tb_fetch_cache.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module tb_fetch_cache;
	import icache_pkg::*;

	localparam int    TIMEOUT_CYCLES = 4000;
	localparam addr_t MH_BASE        = 64'h100;   // Four lines, sets 0x10 to 0x13
	localparam addr_t BP_MISS        = 64'h148;
	localparam addr_t FLUSH_ADDR     = 64'h158;
	localparam addr_t STALE_BASE     = 64'h2054;  // Set 5, tags step by 0x400
	localparam addr_t STREAM_BASE    = 64'h1000;

	logic  clk;
	logic  rst;
	addr_t addr;
	logic  valid;
	logic  flush;
	logic  id_ready;
	inst_t inst;
	logic  inst_ready;
	logic  load_en;
	addr_t load_addr;
	inst_t load_data;

	inst_t       model [`ICACHE_MEM_WORDS];     // Mirror of every word loaded
	int unsigned cycles = 0;

	fetch_cache_top u_dut (
		.clk        (clk),
		.rst        (rst),
		.addr       (addr),
		.valid      (valid),
		.flush      (flush),
		.id_ready   (id_ready),
		.inst       (inst),
		.inst_ready (inst_ready),
		.load_en    (load_en),
		.load_addr  (load_addr),
		.load_data  (load_data)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("Some tests failed");
			$fatal(1, "Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		end
	end

	task automatic check(input logic [63:0] actual, input logic [63:0] expected,
			input string msg);
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s (got %h, expected %h)", $time, msg, actual, expected);
			$display("Some tests failed");
			$fatal(1, "Stopped at the first wrong value");
		end
	endtask

	function automatic inst_t model_word(input addr_t a);
		return model[a[13:2]];
	endfunction

	// One word per cycle, memory sees it from the next cycle on
	task automatic load_word(input addr_t a, input inst_t data);
		load_en   = 1'b1;
		load_addr = a;
		load_data = data;
		@(negedge clk);
		load_en = 1'b0;
		model[a[13:2]] = data;
	endtask

	task automatic load_random(input addr_t base, input int words);
		for (int i = 0; i < words; i++) begin
			load_word(base + addr_t'(4 * i), $urandom());
		end
	endtask

	task automatic fetch_expect(input addr_t a, input inst_t expected, input string msg);
		addr     = a;
		valid    = 1'b1;
		id_ready = 1'b1;
		flush    = 1'b0;
		@(negedge clk);                         // Accepted at the rising edge in between
		check(64'(inst_ready), 64'(1'b1), {msg, ": inst_ready"});
		check(64'(inst), 64'(expected), msg);
		valid = 1'b0;
	endtask

	task automatic fetch(input addr_t a, input string msg);
		fetch_expect(a, model_word(a), msg);
	endtask

	task automatic test_reset();
		check(64'(inst_ready), 64'(1'b0), "inst_ready right after reset");
		repeat (4) begin
			@(negedge clk);
			check(64'(inst_ready), 64'(1'b0), "inst_ready while valid is low");
		end
	endtask

	// Line l misses first on word l, so every word position sees a miss
	task automatic test_miss_hit();
		addr_t base;
		load_random(MH_BASE, 16);
		for (int l = 0; l < 4; l++) begin
			base = MH_BASE + addr_t'(16 * l);
			fetch(base + addr_t'(4 * l), $sformatf("miss on line %0d word %0d", l, l));
			for (int w = 0; w < 4; w++) begin
				fetch(base + addr_t'(4 * w), $sformatf("hit on line %0d word %0d", l, w));
			end
		end
	endtask

	task automatic test_stale_ways();
		addr_t a [4];
		inst_t old_word [4];
		for (int k = 0; k < 4; k++) begin
			a[k] = STALE_BASE + addr_t'(k * 'h400);
			load_word(a[k], $urandom());
			old_word[k] = model_word(a[k]);
		end
		// Pointer moves once per cycle, so each miss fills another way
		id_ready = 1'b1;
		flush    = 1'b0;
		valid    = 1'b1;
		for (int k = 0; k < 4; k++) begin
			addr = a[k];
			@(negedge clk);
			check(64'(inst_ready), 64'(1'b1), $sformatf("stale fill %0d: inst_ready", k));
			check(64'(inst), 64'(old_word[k]), $sformatf("stale fill %0d", k));
		end
		valid = 1'b0;
		for (int k = 0; k < 4; k++) begin
			load_word(a[k], ~old_word[k]);
		end
		for (int k = 0; k < 4; k++) begin
			fetch_expect(a[k], old_word[k], $sformatf("stale hit %0d keeps old word", k));
		end
	endtask

	task automatic test_back_pressure();
		load_random(BP_MISS & ~addr_t'(15), 4);
		fetch(MH_BASE + addr_t'(4), "hit before back-pressure");
		id_ready = 1'b0;
		valid    = 1'b1;                        // Pending request must not be taken
		addr     = BP_MISS;
		repeat (5) begin
			@(negedge clk);
			check(64'(inst_ready), 64'(1'b1), "inst_ready held under back-pressure");
			check(64'(inst), 64'(model_word(MH_BASE + addr_t'(4))),
				"inst held under back-pressure");
		end
		fetch(BP_MISS, "first fetch after back-pressure");
	endtask

	task automatic test_flush();
		load_random(FLUSH_ADDR & ~addr_t'(15), 4);
		fetch(MH_BASE + addr_t'(8), "fetch before flush");
		addr     = FLUSH_ADDR;
		valid    = 1'b1;
		id_ready = 1'b1;
		flush    = 1'b1;
		@(negedge clk);
		check(64'(inst_ready), 64'(1'b0), "inst_ready after flushed request");
		flush = 1'b0;
		valid = 1'b0;
		fetch(FLUSH_ADDR, "refetch after flush");
	endtask

	task automatic test_stream();
		load_random(STREAM_BASE, 64);
		addr     = STREAM_BASE;
		valid    = 1'b1;
		id_ready = 1'b1;
		flush    = 1'b0;
		for (int i = 1; i <= 64; i++) begin
			@(negedge clk);
			check(64'(inst_ready), 64'(1'b1), $sformatf("stream word %0d: inst_ready", i - 1));
			check(64'(inst), 64'(model_word(STREAM_BASE + addr_t'(4 * (i - 1)))),
				$sformatf("stream word %0d", i - 1));
			if (i < 64) begin
				addr = STREAM_BASE + addr_t'(4 * i);
			end else begin
				valid = 1'b0;
			end
		end
	endtask

	initial begin
		void'($urandom(32'h3fea_dafc));
		clk       = 1'b0;
		rst       = 1'b1;
		addr      = '0;
		valid     = 1'b0;
		flush     = 1'b0;
		id_ready  = 1'b1;
		load_en   = 1'b0;
		load_addr = '0;
		load_data = '0;
		for (int i = 0; i < `ICACHE_MEM_WORDS; i++) begin
			model[i] = '0;
		end

		repeat (8) @(negedge clk);
		rst = 1'b0;

		test_reset();
		test_miss_hit();
		test_stale_ways();
		test_back_pressure();
		test_flush();
		test_stream();

		$display("All tests passed");
		$finish;
	end

endmodule
